// ==== common/dma_pkg.sv ====
// Sizes and bus types for the DMA cluster, which assume NB_CORES equals 2**CORE_ID_WIDTH
package dma_pkg;

  localparam int NB_CORES         = 4;
  localparam int CORE_QUEUE_DEPTH = 2;   // Must stay a power of two
  localparam int TCDM_ADDR_WIDTH  = 10;
  localparam int EXT_ADDR_WIDTH   = 16;
  localparam int LEN_WIDTH        = 8;
  localparam int CORE_ID_WIDTH    = 2;

  // Queue bookkeeping widths
  localparam int QPTR_WIDTH = $clog2(CORE_QUEUE_DEPTH);
  localparam int QCNT_WIDTH = $clog2(CORE_QUEUE_DEPTH + 1);
  localparam logic [QCNT_WIDTH-1:0] QUEUE_FULL_CNT = QCNT_WIDTH'(CORE_QUEUE_DEPTH);

  // Control port word offsets, taken from adr[3:2]
  localparam logic [1:0] REG_TCDM_ADDR = 2'd0;
  localparam logic [1:0] REG_EXT_ADDR  = 2'd1;
  localparam logic [1:0] REG_CMD       = 2'd2;
  localparam logic [1:0] REG_STATUS    = 2'd3;

  // Wishbone classic, master to slave
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat;
  } wb_req_t;

  // Wishbone classic, slave to master
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  typedef enum logic {
    EXT_TO_TCDM = 1'b0,
    TCDM_TO_EXT = 1'b1
  } dma_dir_e;

  typedef struct packed {
    logic [22:0]          rsvd;
    dma_dir_e             dir;
    logic [LEN_WIDTH-1:0] len;
  } dma_cmd_t;

  // Write data seen either as a word address or as a command
  typedef union packed {
    logic [31:0] addr;
    dma_cmd_t    cmd;
  } dma_ctrl_word_u;

  typedef struct packed {
    dma_dir_e                   dir;
    logic [LEN_WIDTH-1:0]       len;
    logic [TCDM_ADDR_WIDTH-1:0] tcdm_addr;
    logic [EXT_ADDR_WIDTH-1:0]  ext_addr;
    logic [CORE_ID_WIDTH-1:0]   core_id;
  } dma_job_t;

endpackage

// ==== logic/dma_core_port.sv ====
// Per-core control slave with full-word access only, address bits above [3:2] are ignored
`timescale 1ns/10ps
module dma_core_port (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  dma_pkg::wb_req_t                   wb_req_i,
  output dma_pkg::wb_rsp_t                   wb_rsp_o,
  input  logic [dma_pkg::CORE_ID_WIDTH-1:0]  core_id_i,
  output dma_pkg::dma_job_t                  job_o,
  output logic                               job_valid_o,
  input  logic                               pop_i
);

  dma_pkg::dma_ctrl_word_u                wdata;
  dma_pkg::dma_job_t                      new_job;
  dma_pkg::dma_job_t                      queue_q [dma_pkg::CORE_QUEUE_DEPTH];
  logic [dma_pkg::QPTR_WIDTH-1:0]         wr_ptr_q;
  logic [dma_pkg::QPTR_WIDTH-1:0]         rd_ptr_q;
  logic [dma_pkg::QCNT_WIDTH-1:0]         cnt_q;
  logic [dma_pkg::TCDM_ADDR_WIDTH-1:0]    tcdm_addr_q;
  logic [dma_pkg::EXT_ADDR_WIDTH-1:0]     ext_addr_q;
  logic [1:0]                             reg_off;
  logic                                   req_new;
  logic                                   is_cmd_wr;
  logic                                   full;
  logic                                   accept;
  logic                                   push;
  logic                                   ack_q;
  logic [31:0]                            rdata;
  logic [31:0]                            rdata_q;

  assign wdata     = wb_req_i.dat;
  assign reg_off   = wb_req_i.adr[3:2];
  assign req_new   = wb_req_i.cyc & wb_req_i.stb & ~ack_q;  // Old request still up during ack
  assign is_cmd_wr = wb_req_i.we & (reg_off == dma_pkg::REG_CMD);
  assign full      = (cnt_q == dma_pkg::QUEUE_FULL_CNT);

  // A command on a full queue waits, unless the head leaves this very edge
  assign accept = req_new & (~is_cmd_wr | ~full | pop_i);
  assign push   = accept & is_cmd_wr;

  always_comb begin
    new_job.dir       = wdata.cmd.dir;
    new_job.len       = wdata.cmd.len;
    new_job.tcdm_addr = tcdm_addr_q;
    new_job.ext_addr  = ext_addr_q;
    new_job.core_id   = core_id_i;
  end

  always_comb begin
    rdata = '0;
    case (reg_off)
      dma_pkg::REG_TCDM_ADDR: rdata[dma_pkg::TCDM_ADDR_WIDTH-1:0] = tcdm_addr_q;
      dma_pkg::REG_EXT_ADDR:  rdata[dma_pkg::EXT_ADDR_WIDTH-1:0]  = ext_addr_q;
      dma_pkg::REG_STATUS:    rdata[dma_pkg::QCNT_WIDTH-1:0]      = cnt_q;  // Jobs pending
      default: ;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q    <= 1'b0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      ack_q <= accept;
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps with a power-of-two depth
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: ;
      endcase
    end
  end

  // Address registers, queue slots and read data
  always_ff @(posedge clk_i) begin
    if (accept && wb_req_i.we && reg_off == dma_pkg::REG_TCDM_ADDR) begin
      tcdm_addr_q <= wdata.addr[dma_pkg::TCDM_ADDR_WIDTH-1:0];
    end
    if (accept && wb_req_i.we && reg_off == dma_pkg::REG_EXT_ADDR) begin
      ext_addr_q <= wdata.addr[dma_pkg::EXT_ADDR_WIDTH-1:0];
    end
    if (push) begin
      queue_q[wr_ptr_q] <= new_job;
    end
    if (accept) begin
      rdata_q <= rdata;
    end
  end

  assign job_o       = queue_q[rd_ptr_q];
  assign job_valid_o = (cnt_q != '0);

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rdata_q;

endmodule

// ==== logic/dma_cmd_arbiter.sv ====
// Round-robin over the queue heads; the pointer wraps only when NB_CORES is a power of two
`timescale 1ns/10ps
module dma_cmd_arbiter (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  dma_pkg::dma_job_t [dma_pkg::NB_CORES-1:0] req_jobs_i,
  input  logic [dma_pkg::NB_CORES-1:0]             req_valid_i,
  output logic [dma_pkg::NB_CORES-1:0]             pop_o,
  output dma_pkg::dma_job_t                        job_o,
  output logic                                     job_valid_o,
  input  logic                                     job_take_i
);

  logic [dma_pkg::CORE_ID_WIDTH-1:0] rr_ptr_q;
  logic [dma_pkg::CORE_ID_WIDTH-1:0] sel;
  logic                              found;
  logic                              take;

  // First valid core at or after the pointer
  always_comb begin : sel_logic
    logic [dma_pkg::CORE_ID_WIDTH-1:0] idx;
    found = 1'b0;
    sel   = rr_ptr_q;
    for (int i = 0; i < dma_pkg::NB_CORES; i++) begin
      idx = rr_ptr_q + i[dma_pkg::CORE_ID_WIDTH-1:0];
      if (!found && req_valid_i[idx]) begin
        found = 1'b1;
        sel   = idx;
      end
    end
  end

  assign job_o       = req_jobs_i[sel];
  assign job_valid_o = found;
  assign take        = found & job_take_i;

  always_comb begin
    pop_o = '0;
    if (take) begin
      pop_o[sel] = 1'b1;  // Head leaves on the take edge
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_ptr_q <= '0;
    end else if (take) begin
      rr_ptr_q <= sel + 1'b1;  // Served core goes to the back
    end
  end

endmodule

// ==== engine/dma_engine.sv ====
// Single-word copy engine with one bus cycle at a time and no error or retry handling
`timescale 1ns/10ps
module dma_engine (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  dma_pkg::dma_job_t             job_i,
  input  logic                          job_valid_i,
  output logic                          job_take_o,
  output dma_pkg::wb_req_t              tcdm_req_o,
  input  dma_pkg::wb_rsp_t              tcdm_rsp_i,
  output dma_pkg::wb_req_t              ext_req_o,
  input  dma_pkg::wb_rsp_t              ext_rsp_i,
  output logic [dma_pkg::NB_CORES-1:0]  term_evt_o,
  output logic                          active_o
);

  typedef enum logic [1:0] {
    IDLE,
    READ,
    WRITE,
    DONE
  } state_e;

  state_e                            state_q;
  dma_pkg::dma_job_t                 job_q;      // Address fields advance per word
  logic [dma_pkg::LEN_WIDTH-1:0]     remain_q;
  logic [31:0]                       data_q;
  logic [dma_pkg::NB_CORES-1:0]      term_evt_q;
  logic                              rd_on_ext;
  logic                              rd_ack;
  logic                              wr_ack;
  logic [31:0]                       rd_dat;
  logic                              start;

  assign rd_on_ext = (job_q.dir == dma_pkg::EXT_TO_TCDM);
  assign rd_ack    = rd_on_ext ? ext_rsp_i.ack : tcdm_rsp_i.ack;
  assign rd_dat    = rd_on_ext ? ext_rsp_i.dat : tcdm_rsp_i.dat;
  assign wr_ack    = rd_on_ext ? tcdm_rsp_i.ack : ext_rsp_i.ack;

  assign job_take_o = (state_q == IDLE);
  assign start      = job_take_o & job_valid_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= IDLE;
      remain_q   <= '0;
      term_evt_q <= '0;
    end else begin
      term_evt_q <= '0;
      case (state_q)
        IDLE: begin
          if (start) begin
            remain_q <= job_i.len;
            state_q  <= (job_i.len == '0) ? DONE : READ;  // Empty job only signals
          end
        end
        READ: begin
          if (rd_ack) begin
            state_q <= WRITE;
          end
        end
        WRITE: begin
          if (wr_ack) begin
            remain_q <= remain_q - 1'b1;
            state_q  <= (remain_q == 1) ? DONE : READ;
          end
        end
        DONE: begin
          term_evt_q[job_q.core_id] <= 1'b1;
          state_q                   <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Job copy and word buffer
  always_ff @(posedge clk_i) begin
    if (start) begin
      job_q <= job_i;
    end else if (state_q == WRITE && wr_ack) begin
      job_q.tcdm_addr <= job_q.tcdm_addr + 1'b1;
      job_q.ext_addr  <= job_q.ext_addr + 1'b1;
    end
    if (state_q == READ && rd_ack) begin
      data_q <= rd_dat;
    end
  end

  always_comb begin
    tcdm_req_o     = '0;
    ext_req_o      = '0;
    tcdm_req_o.adr[dma_pkg::TCDM_ADDR_WIDTH-1:0] = job_q.tcdm_addr;
    ext_req_o.adr[dma_pkg::EXT_ADDR_WIDTH-1:0]   = job_q.ext_addr;
    tcdm_req_o.dat = data_q;
    ext_req_o.dat  = data_q;
    if (state_q == READ) begin
      if (rd_on_ext) begin
        ext_req_o.cyc = 1'b1;
        ext_req_o.stb = 1'b1;
      end else begin
        tcdm_req_o.cyc = 1'b1;
        tcdm_req_o.stb = 1'b1;
      end
    end else if (state_q == WRITE) begin
      if (rd_on_ext) begin
        tcdm_req_o.cyc = 1'b1;
        tcdm_req_o.stb = 1'b1;
        tcdm_req_o.we  = 1'b1;
      end else begin
        ext_req_o.cyc = 1'b1;
        ext_req_o.stb = 1'b1;
        ext_req_o.we  = 1'b1;
      end
    end
  end

  assign term_evt_o = term_evt_q;  // One cycle after DONE
  assign active_o   = (state_q != IDLE);

endmodule

// ==== logic/dmac_top.sv ====
// Cluster DMA top with word addresses on both memory masters and one job in flight at a time
`timescale 1ns/10ps
module dmac_top (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  dma_pkg::wb_req_t [dma_pkg::NB_CORES-1:0] ctrl_req_i,
  output dma_pkg::wb_rsp_t [dma_pkg::NB_CORES-1:0] ctrl_rsp_o,
  output dma_pkg::wb_req_t                        tcdm_req_o,
  input  dma_pkg::wb_rsp_t                        tcdm_rsp_i,
  output dma_pkg::wb_req_t                        ext_req_o,
  input  dma_pkg::wb_rsp_t                        ext_rsp_i,
  output logic [dma_pkg::NB_CORES-1:0]            term_evt_o,
  output logic                                    busy_o
);

  dma_pkg::dma_job_t [dma_pkg::NB_CORES-1:0] port_jobs;
  logic [dma_pkg::NB_CORES-1:0]              port_valid;
  logic [dma_pkg::NB_CORES-1:0]              port_pop;
  dma_pkg::dma_job_t                         arb_job;
  logic                                      arb_valid;
  logic                                      eng_take;
  logic                                      eng_active;

  for (genvar k = 0; k < dma_pkg::NB_CORES; k++) begin : g_core_port
    dma_core_port u_core_port (
      .clk_i       ( clk_i                             ),
      .rst_n_i     ( rst_n_i                           ),
      .wb_req_i    ( ctrl_req_i[k]                     ),
      .wb_rsp_o    ( ctrl_rsp_o[k]                     ),
      .core_id_i   ( dma_pkg::CORE_ID_WIDTH'(k)        ),  // Tags jobs for the event
      .job_o       ( port_jobs[k]                      ),
      .job_valid_o ( port_valid[k]                     ),
      .pop_i       ( port_pop[k]                       )
    );
  end

  dma_cmd_arbiter u_arbiter (
    .clk_i       ( clk_i      ),
    .rst_n_i     ( rst_n_i    ),
    .req_jobs_i  ( port_jobs  ),
    .req_valid_i ( port_valid ),
    .pop_o       ( port_pop   ),
    .job_o       ( arb_job    ),
    .job_valid_o ( arb_valid  ),
    .job_take_i  ( eng_take   )
  );

  dma_engine u_engine (
    .clk_i       ( clk_i      ),
    .rst_n_i     ( rst_n_i    ),
    .job_i       ( arb_job    ),
    .job_valid_i ( arb_valid  ),
    .job_take_o  ( eng_take   ),
    .tcdm_req_o  ( tcdm_req_o ),
    .tcdm_rsp_i  ( tcdm_rsp_i ),
    .ext_req_o   ( ext_req_o  ),
    .ext_rsp_i   ( ext_rsp_i  ),
    .term_evt_o  ( term_evt_o ),
    .active_o    ( eng_active )
  );

  // Pending work anywhere in the controller
  assign busy_o = (|port_valid) | eng_active;

endmodule

// ==== dv/dmac_tb_mem.sv ====
// Simulation-only word memory with Wishbone classic timing, address bits above ADDR_WIDTH are dropped
`timescale 1ns/10ps
module dmac_tb_mem #(
  parameter int ADDR_WIDTH = 10
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  dma_pkg::wb_req_t wb_req_i,
  output dma_pkg::wb_rsp_t wb_rsp_o,
  input  logic [1:0]       delay_i    // Extra wait cycles before ack
);

  logic [31:0]           mem [2**ADDR_WIDTH];
  logic [ADDR_WIDTH-1:0] addr;
  logic [1:0]            wait_q;
  logic                  ack_q;
  logic [31:0]           rdat_q;
  logic                  req_new;
  logic                  grant;

  assign addr    = wb_req_i.adr[ADDR_WIDTH-1:0];
  assign req_new = wb_req_i.cyc & wb_req_i.stb & ~ack_q;  // Request is still up during its ack
  assign grant   = req_new & (wait_q >= delay_i);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wait_q <= '0;
      ack_q  <= 1'b0;
    end else begin
      ack_q <= grant;
      if (req_new && !grant) begin
        wait_q <= wait_q + 1'b1;
      end else begin
        wait_q <= '0;
      end
    end
  end

  // Contents are preloaded and inspected by the testbench
  always @(posedge clk_i) begin
    if (grant) begin
      if (wb_req_i.we) begin
        mem[addr] <= wb_req_i.dat;
      end
      rdat_q <= mem[addr];
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rdat_q;

endmodule

// ==== dv/tb_dmac.sv ====
// Each core owns a disjoint slice of both memories, so cross-core event order is free
`timescale 1ns/10ps
module tb_dmac;

  localparam int TCDM_AW     = 10;
  localparam int EXT_AW      = 16;
  localparam int TCDM_WORDS  = 2**TCDM_AW;
  localparam int EXT_WORDS   = 2**EXT_AW;
  localparam int TCDM_SLICE  = TCDM_WORDS / dma_pkg::NB_CORES;
  localparam int EXT_SLICE   = EXT_WORDS / dma_pkg::NB_CORES;
  localparam int MAX_LEN     = 16;
  localparam int NJ_DIR      = 64;   // Jobs per direction
  localparam int NJ_MIX      = 12;   // Jobs per core when all cores run together
  localparam int CYCLE_LIMIT = 200 * MAX_LEN * 10 + 4000;

  typedef struct packed {
    logic dir;
    int   len;
    int   taddr;
    int   eaddr;
  } job_rec_t;

  logic                                      clk;
  logic                                      rst_n;
  dma_pkg::wb_req_t [dma_pkg::NB_CORES-1:0]  ctrl_req;
  dma_pkg::wb_rsp_t [dma_pkg::NB_CORES-1:0]  ctrl_rsp;
  dma_pkg::wb_req_t                          tcdm_req;
  dma_pkg::wb_rsp_t                          tcdm_rsp;
  dma_pkg::wb_req_t                          ext_req;
  dma_pkg::wb_rsp_t                          ext_rsp;
  logic [dma_pkg::NB_CORES-1:0]              term_evt;
  logic                                      busy;
  logic [1:0]                                tcdm_delay;
  logic [1:0]                                ext_delay;

  logic [31:0] lcg_state;
  logic [31:0] shadow_tcdm [TCDM_WORDS];
  logic [31:0] shadow_ext [EXT_WORDS];
  job_rec_t    pend [dma_pkg::NB_CORES][256];   // Per-core ring of jobs awaiting their event
  job_rec_t    mix_jobs [dma_pkg::NB_CORES][NJ_MIX];
  int          issued [dma_pkg::NB_CORES];
  int          seen [dma_pkg::NB_CORES];
  int          cycle_cnt = 0;

  dmac_top u_dut (
    .clk_i      ( clk      ),
    .rst_n_i    ( rst_n    ),
    .ctrl_req_i ( ctrl_req ),
    .ctrl_rsp_o ( ctrl_rsp ),
    .tcdm_req_o ( tcdm_req ),
    .tcdm_rsp_i ( tcdm_rsp ),
    .ext_req_o  ( ext_req  ),
    .ext_rsp_i  ( ext_rsp  ),
    .term_evt_o ( term_evt ),
    .busy_o     ( busy     )
  );

  dmac_tb_mem #(.ADDR_WIDTH(TCDM_AW)) u_tcdm_mem (
    .clk_i(clk), .rst_n_i(rst_n), .wb_req_i(tcdm_req), .wb_rsp_o(tcdm_rsp), .delay_i(tcdm_delay)
  );

  dmac_tb_mem #(.ADDR_WIDTH(EXT_AW)) u_ext_mem (
    .clk_i(clk), .rst_n_i(rst_n), .wb_req_i(ext_req), .wb_rsp_o(ext_rsp), .delay_i(ext_delay)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = lcg_next();
    return int'(r[31:8]) % n;  // Low LCG bits have short periods
  endfunction

  function automatic job_rec_t random_job(input int core, input logic dir);
    job_rec_t rec;
    rec.dir   = dir;
    rec.len   = rand_below(MAX_LEN + 1);
    rec.taddr = core * TCDM_SLICE + rand_below(TCDM_SLICE - MAX_LEN);
    rec.eaddr = core * EXT_SLICE + rand_below(EXT_SLICE - MAX_LEN);
    return rec;
  endfunction

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("FAIL %0t: %s, got %h, expected %h", $time, what, got, exp);
      $display("Testbench failed");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  // One Wishbone classic access on a core port, driven on falling edges
  task automatic bus_access(input int core, input logic we, input logic [1:0] off,
                            input logic [31:0] wdat, output logic [31:0] rdat);
    @(negedge clk);
    ctrl_req[core].cyc = 1'b1;
    ctrl_req[core].stb = 1'b1;
    ctrl_req[core].we  = we;
    ctrl_req[core].adr = {28'd0, off, 2'b00};
    ctrl_req[core].dat = wdat;
    @(negedge clk);
    while (!ctrl_rsp[core].ack) begin
      @(negedge clk);
    end
    rdat           = ctrl_rsp[core].dat;
    ctrl_req[core] = '0;
  endtask

  task automatic issue_job(input int core, input job_rec_t rec);
    logic [31:0] unused;
    pend[core][issued[core] % 256] = rec;
    issued[core]++;
    bus_access(core, 1'b1, dma_pkg::REG_TCDM_ADDR, rec.taddr, unused);
    bus_access(core, 1'b1, dma_pkg::REG_EXT_ADDR, rec.eaddr, unused);
    bus_access(core, 1'b1, dma_pkg::REG_CMD, {23'd0, rec.dir, 8'(rec.len)}, unused);
  endtask

  // Apply the oldest job of the core to the shadows and check its destination
  task automatic retire_job(input int core);
    job_rec_t rec;
    if (seen[core] >= issued[core]) begin
      $display("Event for core %0d arrived with no job outstanding", core);
      $display("Testbench failed");
      $fatal(1, "Unexpected event");
    end
    rec = pend[core][seen[core] % 256];
    seen[core]++;
    for (int i = 0; i < rec.len; i++) begin
      if (rec.dir) begin
        shadow_ext[rec.eaddr + i] = shadow_tcdm[rec.taddr + i];
        check_val(u_ext_mem.mem[rec.eaddr + i], shadow_ext[rec.eaddr + i], "ext destination");
      end else begin
        shadow_tcdm[rec.taddr + i] = shadow_ext[rec.eaddr + i];
        check_val(u_tcdm_mem.mem[rec.taddr + i], shadow_tcdm[rec.taddr + i], "tcdm destination");
      end
    end
  endtask

  task automatic wait_all_done();
    int pending;
    do begin
      @(negedge clk);
      pending = 0;
      for (int k = 0; k < dma_pkg::NB_CORES; k++) begin
        pending += issued[k] - seen[k];
      end
    end while (pending != 0);
  endtask

  task automatic compare_memories(input string phase);
    for (int i = 0; i < TCDM_WORDS; i++) begin
      check_val(u_tcdm_mem.mem[i], shadow_tcdm[i], $sformatf("%s, tcdm word %0d", phase, i));
    end
    for (int i = 0; i < EXT_WORDS; i++) begin
      check_val(u_ext_mem.mem[i], shadow_ext[i], $sformatf("%s, ext word %0d", phase, i));
    end
  endtask

  task automatic run_core_jobs(input int core);
    for (int j = 0; j < NJ_MIX; j++) begin
      issue_job(core, mix_jobs[core][j]);
    end
  endtask

  always @(negedge clk) begin
    if (rst_n) begin
      for (int k = 0; k < dma_pkg::NB_CORES; k++) begin
        if (term_evt[k]) begin
          retire_job(k);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Testbench failed");
      $fatal(1, "Timeout");
    end
  end

  initial begin : main_seq
    job_rec_t    rec;
    int          core;
    int          base;
    int          mix_base [dma_pkg::NB_CORES];
    logic [31:0] rdat;

    clk        = 1'b0;
    rst_n      = 1'b0;
    ctrl_req   = '0;
    tcdm_delay = '0;
    ext_delay  = '0;
    lcg_state  = 32'hadc0_4c2f;
    for (int k = 0; k < dma_pkg::NB_CORES; k++) begin
      issued[k] = 0;
      seen[k]   = 0;
    end
    for (int i = 0; i < TCDM_WORDS; i++) begin
      shadow_tcdm[i]    = lcg_next();
      u_tcdm_mem.mem[i] = shadow_tcdm[i];
    end
    for (int i = 0; i < EXT_WORDS; i++) begin
      shadow_ext[i]    = lcg_next();
      u_ext_mem.mem[i] = shadow_ext[i];
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    check_val(32'(term_evt), 0, "term_evt after reset");
    check_val(32'(busy), 0, "busy after reset");
    check_val(32'(tcdm_req.cyc), 0, "tcdm cyc after reset");
    check_val(32'(ext_req.cyc), 0, "ext cyc after reset");
    for (int k = 0; k < dma_pkg::NB_CORES; k++) begin
      bus_access(k, 1'b0, dma_pkg::REG_STATUS, '0, rdat);
      check_val(rdat, 0, "status after reset");
    end

    // External to TCDM first, then TCDM to external
    for (int n = 0; n < 2 * NJ_DIR; n++) begin
      tcdm_delay = 2'(rand_below(4));
      ext_delay  = 2'(rand_below(4));
      core       = rand_below(dma_pkg::NB_CORES);
      rec        = random_job(core, n >= NJ_DIR);
      issue_job(core, rec);
      if (n == NJ_DIR - 1) begin
        wait_all_done();
        compare_memories("ext to tcdm");
      end
    end
    wait_all_done();
    compare_memories("tcdm to ext");

    // One taken job plus two queued fill the port, so the fourth command stalls
    core = rand_below(dma_pkg::NB_CORES);
    base = seen[core];
    for (int j = 0; j < 4; j++) begin
      rec = random_job(core, rand_below(2) == 1);
      if (j == 0) begin
        rec.len = MAX_LEN;  // Engine stays busy while the queue fills
      end
      issue_job(core, rec);
      if (j == 2) begin
        check_val(seen[core] - base, 0, "queued command acks before first event");
        check_val(32'(busy), 1, "busy while jobs are queued");
        bus_access(core, 1'b0, dma_pkg::REG_STATUS, '0, rdat);
        check_val(rdat, 2, "status with two jobs queued");
      end
    end
    check_val(seen[core] - base, 1, "stalled command ack versus first event");
    wait_all_done();
    compare_memories("back-pressure");

    // All cores at once, each with a length-0 job
    for (int k = 0; k < dma_pkg::NB_CORES; k++) begin
      mix_base[k] = seen[k];
      for (int j = 0; j < NJ_MIX; j++) begin
        mix_jobs[k][j] = random_job(k, rand_below(2) == 1);
        if (j == 1) begin
          mix_jobs[k][j].len = 0;
        end
      end
    end
    tcdm_delay = 2'(rand_below(4));
    ext_delay  = 2'(rand_below(4));
    fork
      run_core_jobs(0);
      run_core_jobs(1);
      run_core_jobs(2);
      run_core_jobs(3);
    join
    wait_all_done();
    repeat (20) @(negedge clk);  // Room for stray events
    for (int k = 0; k < dma_pkg::NB_CORES; k++) begin
      check_val(seen[k] - mix_base[k], NJ_MIX, "event count per core");
    end
    check_val(32'(busy), 0, "busy after all events");
    for (int k = 0; k < dma_pkg::NB_CORES; k++) begin
      bus_access(k, 1'b0, dma_pkg::REG_STATUS, '0, rdat);
      check_val(rdat, 0, "status after all events");
    end
    compare_memories("concurrent cores");

    $display("Testbench passed");
    $finish;
  end

endmodule

// ==== src.f ====
common/dma_pkg.sv
logic/dma_core_port.sv
logic/dma_cmd_arbiter.sv
engine/dma_engine.sv
logic/dmac_top.sv
dv/dmac_tb_mem.sv
dv/tb_dmac.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the DMA testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -Wno-fatal --top-module tb_dmac \
  -f src.f -Mdir "$OBJ" -o sim_dmac
if [ $? -ne 0 ]; then
  echo "ERROR: Verilator build failed"
  exit 1
fi

"./$OBJ/sim_dmac" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "ERROR: simulation exited with status $status"
  exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
  echo "RESULT: pass"
  exit 0
else
  echo "RESULT: pass line not found in $LOG"
  exit 1
fi
